// File: sim/cache_input.txt
# op (0 read, 1 write), address, write data, byte enables, expected read data (hex),
# then expected memory writes and memory reads for the request (decimal)
# clean miss, then hits in the refilled line
0 00001000 00000000 0 a5a51000 0 16
0 00001004 00000000 0 a5a51004 0 0
0 0000103c 00000000 0 a5a5103c 0 0
# partial write hit on bytes 0 and 2
1 00001008 11223344 5 00000000 0 0
0 00001008 00000000 0 a5221044 0 0
# same index with a new tag evicts the dirty line
0 00002008 00000000 0 a5a52008 16 16
0 00001008 00000000 0 a5221044 0 16
0 0000100c 00000000 0 a5a5100c 0 0
# write miss into an empty line
1 00003044 deadbeef c 00000000 0 16
0 00003044 00000000 0 dead3044 0 0
0 00003040 00000000 0 a5a53040 0 0
1 00003040 000000ff f 00000000 0 0
0 00003040 00000000 0 000000ff 0 0
# write miss over a dirty line, then swap the lines back
1 0000107c cafef00d 3 00000000 16 16
0 0000107c 00000000 0 a5a5f00d 0 0
0 00003044 00000000 0 dead3044 16 16
0 00003040 00000000 0 000000ff 0 0
0 0000107c 00000000 0 a5a5f00d 0 16
# both ends of the address space
0 fffff000 00000000 0 5a5af000 0 16
0 00000ffc 00000000 0 a5a50ffc 0 16

// File: cache.f
source/cache_geom_pkg.sv
source/cache_ops_pkg.sv
source/cache_line.sv
source/cache_array.sv
source/cache_ctrl.sv
source/cache_top.sv
sim/cache_tb.sv

// File: Makefile
TOP = cache_tb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --timescale 1ns/1ns -f cache.f --top-module $(TOP) -Mdir obj_dir

run: compile
	out=$$(./obj_dir/V$(TOP)); echo "$$out"; echo "$$out" | grep -q "^Test passed$$"

clean:
	rm -rf obj_dir

// File: sim/cache_tb.sv
`timescale 1ns/1ns

module cache_tb;

  logic                                     clk;
  logic                                     rst;
  logic                                     req;
  cache_ops_pkg::req_op_t                   op;
  logic [31:0]                              addr;
  logic [cache_geom_pkg::data_w-1:0]        wdata;
  logic [cache_geom_pkg::be_w-1:0]          byte_en;
  logic                                     done;
  logic [cache_geom_pkg::data_w-1:0]        rdata;
  logic                                     busy;
  logic                                     mem_req;
  logic                                     mem_we;
  logic [31:0]                              mem_addr;
  logic [cache_geom_pkg::data_w-1:0]        mem_wdata;
  logic                                     mem_ack;
  logic [cache_geom_pkg::data_w-1:0]        mem_rdata;

  // one entry per request line of the stimulus file
  logic [31:0] q_op [$];
  logic [31:0] q_addr [$];
  logic [31:0] q_wdata [$];
  logic [31:0] q_be [$];
  logic [31:0] q_exp [$];
  int          q_wr [$];
  int          q_rd [$];

  logic [31:0] mem_store [bit [31:0]];  // only words written back by the cache
  integer      seed = 32'h5b13;
  int          ack_wait = 0;
  bit          pending = 1'b0;
  int          mem_wr_cnt = 0;
  int          mem_rd_cnt = 0;
  int          done_cnt = 0;
  int          errors = 0;
  int          checks = 0;
  int          cycle_cnt = 0;
  int          cycle_limit = 0;

  cache_top DUT (
    .clk       (clk),
    .rst       (rst),
    .req       (req),
    .op        (op),
    .addr      (addr),
    .wdata     (wdata),
    .byte_en   (byte_en),
    .done      (done),
    .rdata     (rdata),
    .busy      (busy),
    .mem_req   (mem_req),
    .mem_we    (mem_we),
    .mem_addr  (mem_addr),
    .mem_wdata (mem_wdata),
    .mem_ack   (mem_ack),
    .mem_rdata (mem_rdata)
  );

  always #50 clk = ~clk;

  // ----------------------------------------------------------------------
  // backing memory that acknowledges each word after 1 to 4 cycles
  // ----------------------------------------------------------------------
  function automatic logic [31:0] mem_word(input logic [31:0] a);
    if (mem_store.exists(a)) begin
      return mem_store[a];
    end
    return a ^ 32'hA5A5_0000;  // fill pattern from the aligned address
  endfunction

  always @(negedge clk) begin
    if (mem_ack) begin
      mem_ack <= 1'b0;  // the cache drops mem_req after this
    end else if (mem_req === 1'b1) begin
      if (!pending) begin
        pending  = 1'b1;
        ack_wait = {$random(seed)} % 4;
      end
      if (ack_wait == 0) begin
        pending = 1'b0;
        mem_ack <= 1'b1;
        if (mem_we) begin
          mem_store[mem_addr] = mem_wdata;
          mem_wr_cnt++;
        end else begin
          mem_rdata <= mem_word(mem_addr);
          mem_rd_cnt++;
        end
      end else begin
        ack_wait--;
      end
    end
  end

  always @(negedge clk) begin
    if (rst && done) done_cnt++;
  end

  always @(posedge clk) begin
    cycle_cnt++;
    if (cycle_limit > 0 && cycle_cnt > cycle_limit) begin
      $display("timeout after %0d cycles, the cache seems to hang", cycle_cnt);
      $display("Test failed");
      $finish;
    end
  end

  task automatic compare_value(input logic [31:0] got, input logic [31:0] exp,
                               input string what);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("CHECK FAILED at %0t ns: %s, got %h expected %h", $time, what, got, exp);
    end
  endtask

  task automatic load_stimulus();
    int          fd;
    string       line;
    logic [31:0] f_op, f_addr, f_wdata, f_be, f_exp;
    int          f_wr, f_rd;
    fd = $fopen("sim/cache_input.txt", "r");
    if (fd == 0) begin
      $display("could not open the stimulus file sim/cache_input.txt");
    end else begin
      while ($fgets(line, fd) != 0) begin
        // comment and blank lines do not scan
        if ($sscanf(line, "%h %h %h %h %h %d %d",
                    f_op, f_addr, f_wdata, f_be, f_exp, f_wr, f_rd) == 7) begin
          q_op.push_back(f_op);
          q_addr.push_back(f_addr);
          q_wdata.push_back(f_wdata);
          q_be.push_back(f_be);
          q_exp.push_back(f_exp);
          q_wr.push_back(f_wr);
          q_rd.push_back(f_rd);
        end
      end
      $fclose(fd);
    end
  endtask

  // ----------------------------------------------------------------------
  // issue one processor request and wait for done
  // ----------------------------------------------------------------------
  task automatic issue_request(input int i);
    int cycles;
    bit seen_done;
    bit poked;
    cycles    = 0;
    seen_done = 1'b0;
    poked     = 1'b0;
    @(negedge clk);
    mem_wr_cnt = 0;
    mem_rd_cnt = 0;
    req     = 1'b1;
    op      = cache_ops_pkg::req_op_t'(q_op[i][0]);
    addr    = q_addr[i];
    wdata   = q_wdata[i];
    byte_en = q_be[i][3:0];
    while (!seen_done) begin
      @(negedge clk);
      req = 1'b0;
      cycles++;
      if (cycles == 1) begin
        compare_value(32'(busy), 32'd1, $sformatf("request %0d busy after accept", i));
      end
      if (done) begin
        seen_done = 1'b1;
        compare_value(32'(busy), 32'd0, $sformatf("request %0d busy with done", i));
      end else if (cycles == 3 && busy && !poked) begin
        // the cache must drop a stray write in the middle of a miss
        poked   = 1'b1;
        req     = 1'b1;
        op      = cache_ops_pkg::op_write;
        addr    = 32'h0000_1008;
        wdata   = 32'h0BAD_0BAD;
        byte_en = 4'hF;
      end
    end
    if (q_op[i][0] == 1'b0) begin
      compare_value(rdata, q_exp[i], $sformatf("request %0d read data", i));
    end
    compare_value(32'(mem_wr_cnt), 32'(q_wr[i]), $sformatf("request %0d memory writes", i));
    compare_value(32'(mem_rd_cnt), 32'(q_rd[i]), $sformatf("request %0d memory reads", i));
    if (q_wr[i] == 0 && q_rd[i] == 0) begin
      compare_value(32'(cycles), 32'd2, $sformatf("request %0d hit latency", i));
    end
  endtask

  initial begin
    clk       = 1'b0;
    rst       = 1'b0;
    req       = 1'b0;
    op        = cache_ops_pkg::op_read;
    addr      = '0;
    wdata     = '0;
    byte_en   = '0;
    mem_ack   = 1'b0;
    mem_rdata = '0;
    load_stimulus();
    if (q_op.size() == 0) begin
      $display("no requests were read from the stimulus file");
      errors++;
    end else begin
      cycle_limit = q_op.size() * (2 * 16 * 5 + 4) + 10;  // worst case is a dirty miss
      repeat (3) @(negedge clk);
      rst = 1'b1;
      compare_value(32'(done), 32'd0, "done after reset");
      compare_value(32'(busy), 32'd0, "busy after reset");
      compare_value(32'(mem_req), 32'd0, "mem_req after reset");
      compare_value(32'(mem_we), 32'd0, "mem_we after reset");
      for (int i = 0; i < q_op.size(); i++) begin
        issue_request(i);
      end
      repeat (2) @(negedge clk);
      compare_value(32'(done_cnt), 32'(q_op.size()), "done pulses per accepted request");
    end
    $display("checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

// File: source/cache_top.sv
`timescale 1ns/1ns

module cache_top (
  input  logic                              clk,
  input  logic                              rst,
  // processor side
  input  logic                              req,
  input  cache_ops_pkg::req_op_t            op,
  input  logic [31:0]                       addr,
  input  logic [cache_geom_pkg::data_w-1:0] wdata,
  input  logic [cache_geom_pkg::be_w-1:0]   byte_en,
  output logic                              done,
  output logic [cache_geom_pkg::data_w-1:0] rdata,
  output logic                              busy,
  // memory side, one word per transfer
  output logic                              mem_req,
  output logic                              mem_we,
  output logic [31:0]                       mem_addr,
  output logic [cache_geom_pkg::data_w-1:0] mem_wdata,
  input  logic                              mem_ack,
  input  logic [cache_geom_pkg::data_w-1:0] mem_rdata
);

  logic [cache_geom_pkg::index_w-1:0]  index;
  logic [cache_geom_pkg::tag_w-1:0]    req_tag;
  logic [cache_geom_pkg::offset_w-1:0] word_sel;
  logic                                line_we;
  logic [cache_geom_pkg::be_w-1:0]     line_be;
  logic [cache_geom_pkg::data_w-1:0]   line_wdata;
  logic                                set_valid;
  logic                                set_dirty;
  logic [cache_geom_pkg::tag_w-1:0]    new_tag;
  logic                                hit;
  logic                                victim_dirty;
  logic [cache_geom_pkg::tag_w-1:0]    victim_tag;
  logic [cache_geom_pkg::data_w-1:0]   rd_word;

  cache_ctrl u_ctrl (
    .clk          (clk),
    .rst          (rst),
    .req          (req),
    .op           (op),
    .addr         (addr),
    .wdata        (wdata),
    .byte_en      (byte_en),
    .hit          (hit),
    .victim_dirty (victim_dirty),
    .victim_tag   (victim_tag),
    .rd_word      (rd_word),
    .mem_ack      (mem_ack),
    .mem_rdata    (mem_rdata),
    .done         (done),
    .busy         (busy),
    .rdata        (rdata),
    .index        (index),
    .req_tag      (req_tag),
    .word_sel     (word_sel),
    .line_we      (line_we),
    .line_be      (line_be),
    .line_wdata   (line_wdata),
    .set_valid    (set_valid),
    .set_dirty    (set_dirty),
    .new_tag      (new_tag),
    .mem_req      (mem_req),
    .mem_we       (mem_we),
    .mem_addr     (mem_addr),
    .mem_wdata    (mem_wdata)
  );

  cache_array u_array (
    .clk          (clk),
    .rst          (rst),
    .index        (index),
    .word_sel     (word_sel),
    .req_tag      (req_tag),
    .line_we      (line_we),
    .line_be      (line_be),
    .line_wdata   (line_wdata),
    .set_valid    (set_valid),
    .set_dirty    (set_dirty),
    .new_tag      (new_tag),
    .hit          (hit),
    .victim_dirty (victim_dirty),
    .victim_tag   (victim_tag),
    .rd_word      (rd_word)
  );

endmodule

// File: source/cache_ctrl.sv
`timescale 1ns/1ns

module cache_ctrl (
  input  logic                                clk,
  input  logic                                rst,
  input  logic                                req,
  input  cache_ops_pkg::req_op_t              op,
  input  logic [31:0]                         addr,
  input  logic [cache_geom_pkg::data_w-1:0]   wdata,
  input  logic [cache_geom_pkg::be_w-1:0]     byte_en,
  input  logic                                hit,
  input  logic                                victim_dirty,
  input  logic [cache_geom_pkg::tag_w-1:0]    victim_tag,
  input  logic [cache_geom_pkg::data_w-1:0]   rd_word,
  input  logic                                mem_ack,
  input  logic [cache_geom_pkg::data_w-1:0]   mem_rdata,
  output logic                                done,
  output logic                                busy,
  output logic [cache_geom_pkg::data_w-1:0]   rdata,
  output logic [cache_geom_pkg::index_w-1:0]  index,
  output logic [cache_geom_pkg::tag_w-1:0]    req_tag,
  output logic [cache_geom_pkg::offset_w-1:0] word_sel,
  output logic                                line_we,
  output logic [cache_geom_pkg::be_w-1:0]     line_be,
  output logic [cache_geom_pkg::data_w-1:0]   line_wdata,
  output logic                                set_valid,
  output logic                                set_dirty,
  output logic [cache_geom_pkg::tag_w-1:0]    new_tag,
  output logic                                mem_req,
  output logic                                mem_we,
  output logic [31:0]                         mem_addr,
  output logic [cache_geom_pkg::data_w-1:0]   mem_wdata
);

  cache_ops_pkg::ctrl_state_t        state;
  cache_ops_pkg::req_op_t            op_q;
  logic [31:0]                       addr_q;
  logic [cache_geom_pkg::data_w-1:0] wdata_q;
  logic [cache_geom_pkg::be_w-1:0]   be_q;
  logic [cache_geom_pkg::offset_w-1:0] count;  // word counter for line transfers

  logic accept;
  logic acked;
  logic last_word;
  logic write_hit;

  assign busy = (state != cache_ops_pkg::idle) && (state != cache_ops_pkg::respond);
  assign done = (state == cache_ops_pkg::respond);
  assign accept = req && !busy;  // respond also takes a new request
  assign acked = mem_req && mem_ack;
  assign last_word = (count == cache_geom_pkg::offset_w'(cache_geom_pkg::line_words - 1));
  assign write_hit = (state == cache_ops_pkg::lookup) && hit && (op_q == cache_ops_pkg::op_write);

  // request fields
  assign index   = addr_q[cache_geom_pkg::index_lsb +: cache_geom_pkg::index_w];
  assign req_tag = addr_q[cache_geom_pkg::tag_lsb +: cache_geom_pkg::tag_w];
  assign word_sel = (state == cache_ops_pkg::writeback || state == cache_ops_pkg::refill) ?
                    count : addr_q[cache_geom_pkg::offset_lsb +: cache_geom_pkg::offset_w];

  // ----------------------------------------------------------------------
  // memory side
  // ----------------------------------------------------------------------
  assign mem_we    = (state == cache_ops_pkg::writeback);
  assign mem_wdata = rd_word;  // word_sel follows count during write-back
  assign mem_addr  = {mem_we ? victim_tag : req_tag, index, count,
                      {cache_geom_pkg::offset_lsb{1'b0}}};

  // line writes, either a write hit or one refill word per ack
  always_comb begin
    line_we    = write_hit;
    line_be    = be_q;
    line_wdata = wdata_q;
    set_valid  = 1'b1;
    set_dirty  = 1'b1;
    new_tag    = req_tag;
    if (state == cache_ops_pkg::refill) begin
      line_we    = acked;
      line_be    = '1;
      line_wdata = mem_rdata;
      set_valid  = last_word;  // line stays invalid until the last word is in
      set_dirty  = 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      op_q    <= op;
      addr_q  <= addr;
      wdata_q <= wdata;
      be_q    <= byte_en;
    end
    if (state == cache_ops_pkg::lookup && hit && op_q == cache_ops_pkg::op_read) begin
      rdata <= rd_word;
    end
  end

  // ----------------------------------------------------------------------
  // FSM
  // ----------------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (!rst) begin
      state   <= cache_ops_pkg::idle;
      mem_req <= 1'b0;
      count   <= '0;
    end else begin
      case (state)
        cache_ops_pkg::idle, cache_ops_pkg::respond: begin
          state <= accept ? cache_ops_pkg::lookup : cache_ops_pkg::idle;
        end
        cache_ops_pkg::lookup: begin
          count <= '0;
          if (hit) begin
            state <= cache_ops_pkg::respond;
          end else begin
            mem_req <= 1'b1;
            state   <= victim_dirty ? cache_ops_pkg::writeback : cache_ops_pkg::refill;
          end
        end
        cache_ops_pkg::writeback, cache_ops_pkg::refill: begin
          if (acked) begin
            mem_req <= 1'b0;  // one idle cycle between words
            count   <= count + 1'b1;  // wraps to zero after the last word
            if (last_word) begin
              state <= (state == cache_ops_pkg::writeback) ? cache_ops_pkg::refill :
                       cache_ops_pkg::lookup;
            end
          end else if (!mem_req) begin
            mem_req <= 1'b1;
          end
        end
        default: state <= cache_ops_pkg::idle;
      endcase
    end
  end

endmodule

// File: source/cache_array.sv
`timescale 1ns/1ns

module cache_array (
  input  logic                                clk,
  input  logic                                rst,
  input  logic [cache_geom_pkg::index_w-1:0]  index,
  input  logic [cache_geom_pkg::offset_w-1:0] word_sel,
  input  logic [cache_geom_pkg::tag_w-1:0]    req_tag,
  input  logic                                line_we,
  input  logic [cache_geom_pkg::be_w-1:0]     line_be,
  input  logic [cache_geom_pkg::data_w-1:0]   line_wdata,
  input  logic                                set_valid,
  input  logic                                set_dirty,
  input  logic [cache_geom_pkg::tag_w-1:0]    new_tag,
  output logic                                hit,
  output logic                                victim_dirty,
  output logic [cache_geom_pkg::tag_w-1:0]    victim_tag,
  output logic [cache_geom_pkg::data_w-1:0]   rd_word
);

  logic [cache_geom_pkg::num_lines-1:0] line_sel;  // one-hot write strobe

  logic                              valid_q [cache_geom_pkg::num_lines];
  logic                              dirty_q [cache_geom_pkg::num_lines];
  logic [cache_geom_pkg::tag_w-1:0]  tag_q   [cache_geom_pkg::num_lines];
  logic [cache_geom_pkg::data_w-1:0] word_q  [cache_geom_pkg::num_lines];

  always_comb begin
    line_sel        = '0;
    line_sel[index] = line_we;
  end

  for (genvar i = 0; i < cache_geom_pkg::num_lines; i++) begin : g_line
    cache_line u_line (
      .clk       (clk),
      .rst       (rst),
      .write_en  (line_sel[i]),
      .word_sel  (word_sel),
      .byte_en   (line_be),
      .data_in   (line_wdata),
      .valid_in  (set_valid),
      .dirty_in  (set_dirty),
      .tag_in    (new_tag),
      .valid_out (valid_q[i]),
      .dirty_out (dirty_q[i]),
      .tag_out   (tag_q[i]),
      .data_out  (word_q[i])
    );
  end

  // ----------------------------------------------------------------------
  // read side, all combinational from the selected line
  // ----------------------------------------------------------------------
  assign victim_tag   = tag_q[index];
  assign rd_word      = word_q[index];
  assign hit          = valid_q[index] && (tag_q[index] == req_tag);
  assign victim_dirty = valid_q[index] && dirty_q[index];  // needs a write-back on a miss

endmodule

// File: source/cache_line.sv
`timescale 1ns/1ns

module cache_line (
  input  logic                                clk,
  input  logic                                rst,
  input  logic                                write_en,
  input  logic [cache_geom_pkg::offset_w-1:0] word_sel,
  input  logic [cache_geom_pkg::be_w-1:0]     byte_en,
  input  logic [cache_geom_pkg::data_w-1:0]   data_in,
  input  logic                                valid_in,
  input  logic                                dirty_in,
  input  logic [cache_geom_pkg::tag_w-1:0]    tag_in,
  output logic                                valid_out,
  output logic                                dirty_out,
  output logic [cache_geom_pkg::tag_w-1:0]    tag_out,
  output logic [cache_geom_pkg::data_w-1:0]   data_out
);

  logic                              valid_q;
  logic                              dirty_q;
  logic [cache_geom_pkg::tag_w-1:0]  tag_q;
  logic [cache_geom_pkg::data_w-1:0] words [cache_geom_pkg::line_words];

  // status bits
  always_ff @(posedge clk) begin
    if (!rst) begin
      valid_q <= 1'b0;
      dirty_q <= 1'b0;
    end else if (write_en) begin
      valid_q <= valid_in;
      dirty_q <= dirty_in;
    end
  end

  always_ff @(posedge clk) begin
    if (write_en) begin
      tag_q <= tag_in;
    end
  end

  // byte merge into the selected word, other bytes keep their value
  always_ff @(posedge clk) begin
    if (write_en) begin
      for (int b = 0; b < cache_geom_pkg::be_w; b++) begin
        if (byte_en[b]) begin
          words[word_sel][8*b +: 8] <= data_in[8*b +: 8];
        end
      end
    end
  end

  assign valid_out = valid_q;
  assign dirty_out = dirty_q;
  assign tag_out   = tag_q;
  assign data_out  = words[word_sel];

endmodule

// File: source/cache_ops_pkg.sv
package cache_ops_pkg;

  // processor request opcode
  typedef enum logic {
    op_read  = 1'b0,
    op_write = 1'b1
  } req_op_t;

  // ----------------------------------------------------------------------
  // controller states
  // ----------------------------------------------------------------------
  // lookup is entered for every request and again after each refill,
  // so a miss ends up served by the same hit path
  typedef enum logic [2:0] {
    idle      = 3'd0,
    lookup    = 3'd1,
    writeback = 3'd2,
    refill    = 3'd3,
    respond   = 3'd4
  } ctrl_state_t;

endpackage

// File: source/cache_geom_pkg.sv
package cache_geom_pkg;

  // ----------------------------------------------------------------------
  // word and line sizes
  // ----------------------------------------------------------------------
  localparam int data_w     = 32;
  localparam int be_w       = data_w / 8;
  localparam int line_words = 16;
  localparam int num_lines  = 64;

  // ----------------------------------------------------------------------
  // address fields, tag | index | offset | byte
  // ----------------------------------------------------------------------
  localparam int offset_w = 4;  // log2 of line_words
  localparam int index_w  = 6;  // log2 of num_lines
  localparam int tag_w    = 20;

  localparam int offset_lsb = 2;  // two byte bits below the word offset
  localparam int index_lsb  = offset_lsb + offset_w;
  localparam int tag_lsb    = index_lsb + index_w;

endpackage
